//--- dcache.f
+incdir+.
dcache_pkg.sv
dcache_arrays.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_top.sv
dcache_assert.sv
tb_dcache.sv

//--- dcache_arrays.sv
// ######################################
// two-way tag, valid, dirty, line arrays
// with per-set lru and registered read
// ######################################
`include "dcache_defines.svh"
`default_nettype none

module dcache_arrays import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rd_en,
    input  index_t    rd_index,
    input  array_wr_t wr,
    output tag_t      tag0,
    output tag_t      tag1,
    output logic      valid0,
    output logic      valid1,
    output logic      dirty0,
    output logic      dirty1,
    output line_t     line0,
    output line_t     line1,
    output way_t      lru
);

    tag_t  tag_mem   [`DC_WAYS][`DC_SETS];
    line_t line_mem  [`DC_WAYS][`DC_SETS];
    logic  valid_q   [`DC_WAYS][`DC_SETS];
    logic  dirty_q   [`DC_WAYS][`DC_SETS];
    way_t  lru_mem   [`DC_SETS];   // way to replace next

    tag_t  tag_byp   [`DC_WAYS];
    line_t line_byp  [`DC_WAYS];
    logic  valid_byp [`DC_WAYS];
    logic  dirty_byp [`DC_WAYS];
    way_t  lru_byp;

    tag_t  tag_rd    [`DC_WAYS];
    line_t line_rd   [`DC_WAYS];
    logic  valid_rd  [`DC_WAYS];
    logic  dirty_rd  [`DC_WAYS];
    way_t  lru_rd;

    logic  lru_upd;

    assign lru_upd = wr.en || wr.touch;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                for (int s = 0; s < `DC_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
        end else if (wr.en) begin
            valid_q[wr.way][wr.index] <= 1'b1;
            dirty_q[wr.way][wr.index] <= wr.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_mem[wr.way][wr.index]  <= wr.tag;
            line_mem[wr.way][wr.index] <= wr.line;
        end
        if (lru_upd) begin
            lru_mem[wr.index] <= ~wr.way;   // point away from the used way
        end
    end

    // a read of the set being written sees the new contents
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (wr.en && wr.way == way_t'(w) && wr.index == rd_index) begin
                tag_byp[w]   = wr.tag;
                line_byp[w]  = wr.line;
                valid_byp[w] = 1'b1;
                dirty_byp[w] = wr.dirty;
            end else begin
                tag_byp[w]   = tag_mem[w][rd_index];
                line_byp[w]  = line_mem[w][rd_index];
                valid_byp[w] = valid_q[w][rd_index];
                dirty_byp[w] = dirty_q[w][rd_index];
            end
        end
        if (lru_upd && wr.index == rd_index) begin
            lru_byp = ~wr.way;
        end else begin
            lru_byp = lru_mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin            // held while the pipe is stalled
            tag_rd   <= tag_byp;
            line_rd  <= line_byp;
            valid_rd <= valid_byp;
            dirty_rd <= dirty_byp;
            lru_rd   <= lru_byp;
        end
    end

    assign tag0   = tag_rd[0];
    assign tag1   = tag_rd[1];
    assign valid0 = valid_rd[0];
    assign valid1 = valid_rd[1];
    assign dirty0 = dirty_rd[0];
    assign dirty1 = dirty_rd[1];
    assign line0  = line_rd[0];
    assign line1  = line_rd[1];
    assign lru    = lru_rd;

endmodule

`default_nettype wire

//--- dcache_assert.sv
// ######################################
// protocol assertions bound to dcache_top
// ######################################
`default_nettype none

module dcache_assert (
    input logic clk,
    input logic rst_n,
    input logic drq,
    input logic dc_en,
    input logic data_valid,
    input logic miss_stall
);

    timeunit 1ns;
    timeprecision 1ps;

    // a new l2 request starts only while l2 can take it
    drq_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(drq) |-> dc_en)
        else $error("drq rose while dc_en was low");

    valid_not_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_valid && miss_stall))
        else $error("data_valid high while miss_stall is high");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!miss_stall && !drq))
        else $error("miss_stall or drq high right after reset");

endmodule

bind dcache_top dcache_assert dcache_assert_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .drq        (drq),
    .dc_en      (dc_en),
    .data_valid (data_valid),
    .miss_stall (miss_stall)
);

`default_nettype wire

//--- dcache_ctrl.sv
// ######################################
// miss control fsm: hits, writeback,
// refill, cpu stall and l2 requests
// ######################################
`include "dcache_defines.svh"
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       access_mem,
    input  lookup_t    lookup,
    input  logic       dc_en,
    input  logic       l2_complete,
    input  logic       l2_rdy,
    input  line_t      data_wd_l2,
    output logic       rd_en,
    output array_wr_t  arr_wr,
    output word_t      read_data_m,
    output logic       data_valid,
    output logic       miss_stall,
    output logic       drq,
    output logic       l2_cache_rw,
    output line_addr_t l2_addr,
    output line_t      rd_to_l2
);

    dc_state_t state_q;
    dc_state_t state_d;
    logic      fill_done_q;     // read refill word ready
    word_t     fill_word_q;
    line_t     fill_line_q;     // refilled line for a write miss
    index_t    req_index;
    offset_t   req_offset;
    logic      wb_sel;

    assign req_index  = addr_index(lookup.req.addr);
    assign req_offset = addr_offset(lookup.req.addr);

    // writeback phase of a dirty miss
    assign wb_sel = (state_q == WAIT_L2_DIRTY) || (state_q == WRITE_L2) ||
                    (state_q == CHECK && !lookup.hit && lookup.victim_dirty);

    assign l2_cache_rw = wb_sel;
    assign l2_addr     = wb_sel ? {lookup.victim_tag, req_index} : addr_line(lookup.req.addr);
    assign rd_to_l2    = lookup.victim_line;
    assign read_data_m = fill_done_q ? fill_word_q : lookup.hit_word;

    always_comb begin
        state_d          = state_q;
        rd_en            = 1'b0;
        miss_stall       = 1'b1;
        data_valid       = fill_done_q;
        drq              = 1'b0;
        arr_wr           = '0;
        arr_wr.index     = req_index;
        arr_wr.tag       = addr_tag(lookup.req.addr);
        arr_wr.way       = lookup.victim_way;
        case (state_q)
            IDLE: begin
                miss_stall = 1'b0;
                rd_en      = access_mem;
                if (access_mem) begin
                    state_d = CHECK;
                end
            end
            CHECK: begin
                if (lookup.hit && !lookup.req.write) begin       // read hit
                    miss_stall   = 1'b0;
                    data_valid   = 1'b1;
                    arr_wr.touch = 1'b1;
                    arr_wr.way   = lookup.hit_way;
                    rd_en        = access_mem;
                    state_d      = access_mem ? CHECK : IDLE;
                end else if (lookup.hit) begin                    // write hit
                    arr_wr.en    = 1'b1;
                    arr_wr.way   = lookup.hit_way;
                    arr_wr.line  = line_merge(lookup.victim_line, req_offset,
                                              lookup.req.wr_data);
                    arr_wr.dirty = 1'b1;
                    state_d      = IDLE;
                end else if (dc_en) begin
                    drq     = 1'b1;
                    state_d = lookup.victim_dirty ? WRITE_L2 : REFILL;
                end else begin
                    state_d = lookup.victim_dirty ? WAIT_L2_DIRTY : WAIT_L2_CLEAN;
                end
            end
            WAIT_L2_CLEAN: begin
                if (dc_en) begin
                    drq     = 1'b1;
                    state_d = REFILL;
                end
            end
            WAIT_L2_DIRTY: begin
                if (dc_en) begin
                    drq     = 1'b1;
                    state_d = WRITE_L2;
                end
            end
            WRITE_L2: begin
                drq = 1'b1;
                if (l2_complete) begin
                    state_d = REFILL;   // drq stays up for the refill
                end
            end
            REFILL: begin
                drq = 1'b1;
                if (l2_rdy) begin
                    arr_wr.en   = 1'b1;     // clean line into the victim way
                    arr_wr.line = data_wd_l2;
                    state_d     = lookup.req.write ? WRITE_HIT : IDLE;
                end
            end
            WRITE_HIT: begin
                arr_wr.en    = 1'b1;
                arr_wr.line  = line_merge(fill_line_q, req_offset, lookup.req.wr_data);
                arr_wr.dirty = 1'b1;
                state_d      = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            fill_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            fill_done_q <= (state_q == REFILL) && l2_rdy && !lookup.req.write;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REFILL && l2_rdy) begin
            fill_word_q <= line_word(data_wd_l2, req_offset);
            fill_line_q <= data_wd_l2;
        end
    end

endmodule

`default_nettype wire

//--- dcache_defines.svh
// ######################################
// dcache address, word and line widths
// and cache geometry macros
// ######################################
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cpu side
`define DC_ADDR_W       30      // word address
`define DC_WORD_W       32      // data word

// address split: tag | index | offset
`define DC_TAG_W        20
`define DC_INDEX_W      8
`define DC_OFFSET_W     2

// line and l2 side
`define DC_LINE_W       128     // four words, word 0 low
`define DC_WORDS        4       // words per line
`define DC_LINE_ADDR_W  28      // tag plus index

// geometry
`define DC_WAYS         2
`define DC_SETS         256     // 2 ** DC_INDEX_W

`endif

//--- dcache_lookup.sv
// ######################################
// tag compare stage: hit, victim, word
// ######################################
`include "dcache_defines.svh"
`default_nettype none

module dcache_lookup import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  cpu_req_t req_in,
    input  logic     req_take,
    input  tag_t     tag0,
    input  tag_t     tag1,
    input  logic     valid0,
    input  logic     valid1,
    input  logic     dirty0,
    input  logic     dirty1,
    input  line_t    line0,
    input  line_t    line1,
    input  way_t     lru,
    output lookup_t  result
);

    cpu_req_t req_q;
    tag_t     req_tag;
    logic     hit0;
    logic     hit1;
    way_t     hit_way;
    way_t     victim_way;
    line_t    hit_line;

    // request travels with the array read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (req_take) begin
            req_q <= req_in;
        end
    end

    assign req_tag = addr_tag(req_q.addr);
    assign hit0    = valid0 && (tag0 == req_tag);
    assign hit1    = valid1 && (tag1 == req_tag);
    assign hit_way = hit0 ? 1'b0 : 1'b1;
    assign hit_line = hit_way ? line1 : line0;

    always_comb begin
        if (hit0 || hit1) begin
            victim_way = hit_way;   // line to merge into on a write hit
        end else if (!valid0) begin
            victim_way = 1'b0;
        end else if (!valid1) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru;
        end
    end

    always_comb begin
        result.hit          = hit0 || hit1;
        result.hit_way      = hit_way;
        result.victim_way   = victim_way;
        result.victim_dirty = victim_way ? (valid1 && dirty1) : (valid0 && dirty0);
        result.victim_tag   = victim_way ? tag1 : tag0;
        result.victim_line  = victim_way ? line1 : line0;
        result.hit_word     = line_word(hit_line, addr_offset(req_q.addr));
        result.req          = req_q;
    end

endmodule

`default_nettype wire

//--- dcache_pkg.sv
// ######################################
// dcache types, structs, state enum
// and address and line helpers
// ######################################
`include "dcache_defines.svh"
`default_nettype none

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]      addr_t;
    typedef logic [`DC_WORD_W-1:0]      word_t;
    typedef logic [`DC_TAG_W-1:0]       tag_t;
    typedef logic [`DC_INDEX_W-1:0]     index_t;
    typedef logic [`DC_OFFSET_W-1:0]    offset_t;
    typedef logic [`DC_LINE_W-1:0]      line_t;
    typedef logic [`DC_LINE_ADDR_W-1:0] line_addr_t;
    typedef logic                       way_t;

    typedef struct packed {
        addr_t addr;
        logic  write;       // 1 = store
        word_t wr_data;
    } cpu_req_t;

    typedef struct packed {
        logic     hit;
        way_t     hit_way;
        way_t     victim_way;   // equals hit_way on a hit
        logic     victim_dirty; // valid and dirty
        tag_t     victim_tag;
        line_t    victim_line;  // hit line on a hit
        word_t    hit_word;
        cpu_req_t req;
    } lookup_t;

    typedef struct packed {
        logic   en;         // full line write
        way_t   way;
        index_t index;
        tag_t   tag;
        line_t  line;
        logic   dirty;
        logic   touch;      // lru update only
    } array_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        WAIT_L2_CLEAN,
        WAIT_L2_DIRTY,
        WRITE_L2,
        REFILL,
        WRITE_HIT
    } dc_state_t;

    function automatic tag_t addr_tag(input addr_t a);
        return a[`DC_ADDR_W-1 -: `DC_TAG_W];
    endfunction

    function automatic index_t addr_index(input addr_t a);
        return a[`DC_OFFSET_W +: `DC_INDEX_W];
    endfunction

    function automatic offset_t addr_offset(input addr_t a);
        return a[`DC_OFFSET_W-1:0];
    endfunction

    function automatic line_addr_t addr_line(input addr_t a);
        return a[`DC_ADDR_W-1:`DC_OFFSET_W];
    endfunction

    function automatic word_t line_word(input line_t l, input offset_t o);
        return l[o*`DC_WORD_W +: `DC_WORD_W];
    endfunction

    // replace one word of a line
    function automatic line_t line_merge(input line_t l, input offset_t o, input word_t w);
        line_t m;
        m = l;
        m[o*`DC_WORD_W +: `DC_WORD_W] = w;
        return m;
    endfunction

endpackage

`default_nettype wire

//--- dcache_top.sv
// ######################################
// dcache top: arrays, lookup, control
// ######################################
`include "dcache_defines.svh"
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // cpu side
    input  logic       access_mem,
    input  addr_t      addr,
    input  logic       memwrite_m,
    input  word_t      wr_data,
    output word_t      read_data_m,
    output logic       data_valid,
    output logic       miss_stall,
    // l2 side
    output logic       drq,
    output logic       l2_cache_rw,
    output line_addr_t l2_addr,
    output line_t      rd_to_l2,
    input  logic       dc_en,
    input  logic       l2_complete,
    input  logic       l2_rdy,
    input  line_t      data_wd_l2
);

    cpu_req_t  cpu_req;
    lookup_t   lookup;
    array_wr_t arr_wr;
    logic      rd_en;
    tag_t      tag0;
    tag_t      tag1;
    logic      valid0;
    logic      valid1;
    logic      dirty0;
    logic      dirty1;
    line_t     line0;
    line_t     line1;
    way_t      lru;

    assign cpu_req = '{addr: addr, write: memwrite_m, wr_data: wr_data};

    dcache_arrays dcache_arrays_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_index (addr_index(cpu_req.addr)),
        .wr       (arr_wr),
        .tag0     (tag0),
        .tag1     (tag1),
        .valid0   (valid0),
        .valid1   (valid1),
        .dirty0   (dirty0),
        .dirty1   (dirty1),
        .line0    (line0),
        .line1    (line1),
        .lru      (lru)
    );

    dcache_lookup dcache_lookup_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_in   (cpu_req),
        .req_take (rd_en),          // request and set read move together
        .tag0     (tag0),
        .tag1     (tag1),
        .valid0   (valid0),
        .valid1   (valid1),
        .dirty0   (dirty0),
        .dirty1   (dirty1),
        .line0    (line0),
        .line1    (line1),
        .lru      (lru),
        .result   (lookup)
    );

    dcache_ctrl dcache_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .access_mem  (access_mem),
        .lookup      (lookup),
        .dc_en       (dc_en),
        .l2_complete (l2_complete),
        .l2_rdy      (l2_rdy),
        .data_wd_l2  (data_wd_l2),
        .rd_en       (rd_en),
        .arr_wr      (arr_wr),
        .read_data_m (read_data_m),
        .data_valid  (data_valid),
        .miss_stall  (miss_stall),
        .drq         (drq),
        .l2_cache_rw (l2_cache_rw),
        .l2_addr     (l2_addr),
        .rd_to_l2    (rd_to_l2)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the dcache testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_dcache \
    -f dcache.f --Mdir obj_dir -o sim_dcache || exit 1
sim_out=$(./obj_dir/sim_dcache)
echo "$sim_out"
echo "$sim_out" | grep -qx "sim passed" && exit 0 || exit 1

//--- tb_dcache.sv
// ########################################
// dcache testbench: clock, reset, l2 model,
// stimulus table, reference model, checks
// ########################################
`include "dcache_defines.svh"
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NSTEPS  = 23;
    localparam int TIMEOUT = 200;       // cycles per wait

    localparam tag_t   TAG_A = 20'h0a1b2;
    localparam tag_t   TAG_B = 20'h13c4d;
    localparam tag_t   TAG_C = 20'h25e6f;
    localparam tag_t   TAG_D = 20'h31111;
    localparam tag_t   TAG_E = 20'h42222;
    localparam tag_t   TAG_F = 20'h53333;
    localparam tag_t   TAG_G = 20'h64444;
    localparam tag_t   TAG_H = 20'h75555;
    localparam index_t SET_S = 8'h3c;
    localparam index_t SET_T = 8'h7d;
    localparam index_t SET_U = 8'hc2;

    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wr_data;
        word_t exp_word;    // filled in by the model
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        access_mem;
    addr_t       addr;
    logic        memwrite_m;
    word_t       wr_data;
    word_t       read_data_m;
    logic        data_valid;
    logic        miss_stall;
    logic        drq;
    logic        l2_cache_rw;
    line_addr_t  l2_addr;
    line_t       rd_to_l2;
    logic        dc_en;
    logic        l2_complete;
    logic        l2_rdy;
    line_t       data_wd_l2;

    step_t       steps     [NSTEPS];
    string       step_name [NSTEPS];

    logic        sh_valid [`DC_WAYS][`DC_SETS];    // shadow cache state
    tag_t        sh_tag   [`DC_WAYS][`DC_SETS];
    logic        sh_dirty [`DC_WAYS][`DC_SETS];
    way_t        sh_lru   [`DC_SETS];
    word_t       ref_word [addr_t];                 // words written so far

    line_t       l2_mem [line_addr_t];              // lines written back
    int          wb_count;
    line_addr_t  wb_addr;
    line_t       wb_line;
    int          fill_count;
    line_addr_t  fill_addr;
    int          en_left;

    int          errors;
    int          timeouts;
    logic        hung;

    dcache_top dcache_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .access_mem  (access_mem),
        .addr        (addr),
        .memwrite_m  (memwrite_m),
        .wr_data     (wr_data),
        .read_data_m (read_data_m),
        .data_valid  (data_valid),
        .miss_stall  (miss_stall),
        .drq         (drq),
        .l2_cache_rw (l2_cache_rw),
        .l2_addr     (l2_addr),
        .rd_to_l2    (rd_to_l2),
        .dc_en       (dc_en),
        .l2_complete (l2_complete),
        .l2_rdy      (l2_rdy),
        .data_wd_l2  (data_wd_l2)
    );

    always #50 clk = ~clk;

    // memory contents before any writeback
    function automatic word_t pattern_word(input addr_t a);
        return {2'b10, a};
    endfunction

    function automatic word_t ref_word_at(input addr_t a);
        if (ref_word.exists(a)) begin
            return ref_word[a];
        end
        return pattern_word(a);
    endfunction

    function automatic line_t ref_line(input line_addr_t la);
        line_t l;
        for (int i = 0; i < `DC_WORDS; i++) begin
            l[i*32 +: 32] = ref_word_at({la, offset_t'(i)});
        end
        return l;
    endfunction

    function automatic line_t l2_line(input line_addr_t la);
        line_t l;
        if (l2_mem.exists(la)) begin
            return l2_mem[la];
        end
        for (int i = 0; i < `DC_WORDS; i++) begin
            l[i*32 +: 32] = pattern_word({la, offset_t'(i)});
        end
        return l;
    endfunction

    // two-way lru write-back cache, address split tag | index | offset
    function automatic void model_step(input addr_t a, input logic wr, input word_t wd,
                                       output logic hit, output logic wb,
                                       output line_addr_t wb_la, output line_t wb_ln,
                                       output word_t rd);
        tag_t   t;
        index_t s;
        way_t   w;
        t     = a[29:10];
        s     = a[9:2];
        hit   = 1'b0;
        wb    = 1'b0;
        w     = 1'b0;
        wb_la = '0;
        wb_ln = '0;
        for (int k = 0; k < `DC_WAYS; k++) begin
            if (sh_valid[k][s] && sh_tag[k][s] == t) begin
                hit = 1'b1;
                w   = way_t'(k);
            end
        end
        if (!hit) begin
            if (!sh_valid[0][s]) begin
                w = 1'b0;
            end else if (!sh_valid[1][s]) begin
                w = 1'b1;
            end else begin
                w = sh_lru[s];
            end
            if (sh_valid[w][s] && sh_dirty[w][s]) begin
                wb    = 1'b1;
                wb_la = {sh_tag[w][s], s};
                wb_ln = ref_line(wb_la);
            end
            sh_valid[w][s] = 1'b1;
            sh_tag[w][s]   = t;
            sh_dirty[w][s] = 1'b0;
        end
        if (wr) begin
            ref_word[a]    = wd;
            sh_dirty[w][s] = 1'b1;
        end
        sh_lru[s] = ~w;     // other way goes next
        rd = ref_word_at(a);
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [127:0] exp, input logic [127:0] act);
        $display("FAIL %s %s: expected %0h, actual %0h", test, what, exp, act);
        errors++;
    endtask

    task automatic set_step(input int i, input string name, input tag_t t, input index_t s,
                            input offset_t o, input logic wr, input word_t d);
        step_name[i]      = name;
        steps[i].addr     = {t, s, o};
        steps[i].write    = wr;
        steps[i].wr_data  = d;
        steps[i].exp_word = '0;
    endtask

    task automatic build_table();
        set_step(0,  "rd_miss_a1",    TAG_A, SET_S, 2'd1, 1'b0, 32'h0);
        set_step(1,  "rd_hit_a2",     TAG_A, SET_S, 2'd2, 1'b0, 32'h0);
        set_step(2,  "rd_hit_a0",     TAG_A, SET_S, 2'd0, 1'b0, 32'h0);
        set_step(3,  "wr_hit_a3",     TAG_A, SET_S, 2'd3, 1'b1, 32'hdeadbeef);
        set_step(4,  "rd_hit_a3",     TAG_A, SET_S, 2'd3, 1'b0, 32'h0);
        set_step(5,  "rd_hit_a1",     TAG_A, SET_S, 2'd1, 1'b0, 32'h0);
        set_step(6,  "rd_miss_b0",    TAG_B, SET_S, 2'd0, 1'b0, 32'h0);
        set_step(7,  "rd_evict_a_c2", TAG_C, SET_S, 2'd2, 1'b0, 32'h0);
        set_step(8,  "rd_back_a3",    TAG_A, SET_S, 2'd3, 1'b0, 32'h0);
        set_step(9,  "rd_miss_d0",    TAG_D, SET_T, 2'd0, 1'b0, 32'h0);
        set_step(10, "rd_miss_e0",    TAG_E, SET_T, 2'd0, 1'b0, 32'h0);
        set_step(11, "rd_hit_d1",     TAG_D, SET_T, 2'd1, 1'b0, 32'h0);
        set_step(12, "rd_miss_f0",    TAG_F, SET_T, 2'd0, 1'b0, 32'h0);
        set_step(13, "rd_hit_d2",     TAG_D, SET_T, 2'd2, 1'b0, 32'h0);
        set_step(14, "rd_miss_e1",    TAG_E, SET_T, 2'd1, 1'b0, 32'h0);
        set_step(15, "wr_miss_g1",    TAG_G, SET_U, 2'd1, 1'b1, 32'h12345678);
        set_step(16, "rd_hit_g1",     TAG_G, SET_U, 2'd1, 1'b0, 32'h0);
        set_step(17, "rd_hit_g0",     TAG_G, SET_U, 2'd0, 1'b0, 32'h0);
        set_step(18, "wr_hit_c0",     TAG_C, SET_S, 2'd0, 1'b1, 32'hcafef00d);
        set_step(19, "wr_hit_a0",     TAG_A, SET_S, 2'd0, 1'b1, 32'h0badc0de);
        set_step(20, "wr_miss_h2",    TAG_H, SET_S, 2'd2, 1'b1, 32'h5eed5eed);
        set_step(21, "rd_hit_h2",     TAG_H, SET_S, 2'd2, 1'b0, 32'h0);
        set_step(22, "rd_miss_c0",    TAG_C, SET_S, 2'd0, 1'b0, 32'h0);
    endtask

    task automatic run_step(input int i);
        logic       exp_hit;
        logic       exp_wb;
        line_addr_t exp_wb_la;
        line_t      exp_wb_line;
        word_t      exp_word;
        word_t      act_word;
        int         wb_before;
        int         fill_before;
        int         n;
        int         exp_cycles;
        logic       done;
        logic       saw_drq;

        model_step(steps[i].addr, steps[i].write, steps[i].wr_data,
                   exp_hit, exp_wb, exp_wb_la, exp_wb_line, exp_word);
        steps[i].exp_word = exp_word;
        wb_before   = wb_count;
        fill_before = fill_count;
        exp_cycles  = steps[i].write ? 2 : 1;   // write hit stalls one cycle

        @(posedge clk);
        #1;
        access_mem = 1'b1;
        addr       = steps[i].addr;
        memwrite_m = steps[i].write;
        wr_data    = steps[i].wr_data;

        n = 0;
        @(negedge clk);
        while (miss_stall && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (miss_stall) begin
            $display("timeout: request of %s was never accepted", step_name[i]);
            timeouts++;
            hung = 1'b1;
            return;
        end
        @(posedge clk);         // accepted here
        #1;
        access_mem = 1'b0;      // addr and data stay put

        n        = 0;
        done     = 1'b0;
        saw_drq  = 1'b0;
        act_word = '0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            saw_drq  = saw_drq || drq;
            done     = steps[i].write ? !miss_stall : data_valid;
            act_word = read_data_m;
        end
        if (!done) begin
            $display("timeout: %s did not complete within %0d cycles", step_name[i], TIMEOUT);
            timeouts++;
            hung = 1'b1;
            return;
        end

        if (exp_hit) begin
            if (n != exp_cycles) begin
                report_mismatch(step_name[i], "latency", exp_cycles, n);
            end
            if (saw_drq) begin
                $display("%s: drq went high on a cache hit", step_name[i]);
                errors++;
            end
        end else if (fill_count != fill_before + 1) begin
            report_mismatch(step_name[i], "refill count", fill_before + 1, fill_count);
        end else if (fill_addr != steps[i].addr[29:2]) begin
            report_mismatch(step_name[i], "refill address", steps[i].addr[29:2], fill_addr);
        end

        if (wb_count != wb_before + int'(exp_wb)) begin
            report_mismatch(step_name[i], "writeback count", wb_before + int'(exp_wb),
                            wb_count);
        end else if (exp_wb) begin
            if (wb_addr != exp_wb_la) begin
                report_mismatch(step_name[i], "writeback address", exp_wb_la, wb_addr);
            end
            if (wb_line != exp_wb_line) begin
                report_mismatch(step_name[i], "writeback line", exp_wb_line, wb_line);
            end
        end

        if (!steps[i].write && act_word != steps[i].exp_word) begin
            report_mismatch(step_name[i], "read data", steps[i].exp_word, act_word);
        end
    endtask

    // l2 availability, low for 0 to 3 cycles at a time
    always @(posedge clk) begin : l2_enable
        #1;
        if (en_left > 0) begin
            en_left = en_left - 1;
        end else if (dc_en) begin
            en_left = $urandom_range(3, 0);
            if (en_left > 0) begin
                dc_en   = 1'b0;
                en_left = en_left - 1;
            end
        end else begin
            dc_en   = 1'b1;
            en_left = $urandom_range(3, 0);
        end
    end

    // l2 memory, answers after 1 to 4 cycles
    always begin : l2_service
        line_addr_t la;
        int         delay;
        @(negedge clk);
        if (rst_n && drq) begin
            la    = l2_addr;
            delay = $urandom_range(4, 1);
            if (l2_cache_rw) begin
                wb_count++;
                wb_addr    = la;
                wb_line    = rd_to_l2;
                l2_mem[la] = rd_to_l2;
                repeat (delay) @(posedge clk);
                #1;
                l2_complete = 1'b1;
                @(posedge clk);
                #1;
                l2_complete = 1'b0;
            end else begin
                fill_count++;
                fill_addr = la;
                repeat (delay) @(posedge clk);
                #1;
                data_wd_l2 = l2_line(la);
                l2_rdy     = 1'b1;
                @(posedge clk);
                #1;
                l2_rdy = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(32'h4f671c4a));
        clk         = 1'b0;
        rst_n       = 1'b0;
        access_mem  = 1'b0;
        addr        = '0;
        memwrite_m  = 1'b0;
        wr_data     = '0;
        dc_en       = 1'b0;
        l2_complete = 1'b0;
        l2_rdy      = 1'b0;
        data_wd_l2  = '0;
        en_left     = 0;
        wb_count    = 0;
        fill_count  = 0;
        wb_addr     = '0;
        wb_line     = '0;
        fill_addr   = '0;
        errors      = 0;
        timeouts    = 0;
        hung        = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                sh_valid[w][s] = 1'b0;
                sh_dirty[w][s] = 1'b0;
            end
        end
        build_table();

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < NSTEPS; i++) begin
            run_step(i);
            if (hung) begin
                break;
            end
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
